// ==== src/robocup_pkg.sv ====
// Shared widths, command codes and command-byte view; codes are 7 bits under a read/write MSB
package robocup_pkg;

    // Bits per SPI byte, MSB first on the wire
    localparam int SPI_BYTE_WIDTH = 8;
    // Motor duty cycle, two bytes on the bus with the upper bits zero
    localparam int DUTY_WIDTH = 10;
    // Signed encoder count, wraps modulo 2^16
    localparam int ENC_COUNT_WIDTH = 16;
    // Request and response buffers hold one full transfer
    localparam int RESP_BUF_LEN = 12;

    // Command codes in the low 7 bits of the first byte
    localparam logic [SPI_BYTE_WIDTH-2:0] CMD_UPDATE_MTRS = 7'h00;
    localparam logic [SPI_BYTE_WIDTH-2:0] CMD_ENCODER_COUNT = 7'h11;
    localparam logic [SPI_BYTE_WIDTH-2:0] CMD_DUTY_CYCLE = 7'h13;
    localparam logic [SPI_BYTE_WIDTH-2:0] CMD_TOGGLE_MOTOR_EN = 7'h30;

    // Read type in the MSB of the command byte, write type is 0
    localparam logic CMD_READ = 1'b1;

    // Returned for read commands that are not decoded
    localparam logic [SPI_BYTE_WIDTH-1:0] FILL_BYTE = 8'hAA;

    // First request byte: raw data, or read/write flag over a command code
    typedef union packed {
        logic [SPI_BYTE_WIDTH-1:0] raw;
        struct packed {
            logic                      rw;
            logic [SPI_BYTE_WIDTH-2:0] code;
        } cmd;
    } cmd_byte_u;

endpackage

// ==== src/quad_encoder_counter.sv ====
// Quadrature counter for one encoder; steps faster than one per two sysclk cycles are lost
module quad_encoder_counter (
    input  logic                                    sysclk,
    input  logic                                    watchdog_timer_reset_flag,
    input  logic                                    enc_a_i,
    input  logic                                    enc_b_i,
    output logic [robocup_pkg::ENC_COUNT_WIDTH-1:0] enc_count_o
);

    // Two-flop synchronizers plus the previous synchronized state
    logic [1:0] a_sync;
    logic [1:0] b_sync;
    logic       a_prev;
    logic       b_prev;
    logic       step;
    logic       count_up;

    // Exactly one of A and B changed, so a legal single step
    assign step = (a_sync[1] ^ a_prev) ^ (b_sync[1] ^ b_prev);
    // New A against old B gives the direction, high when A leads
    assign count_up = a_sync[1] ^ b_prev;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            a_sync      <= '0;
            b_sync      <= '0;
            a_prev      <= 1'b0;
            b_prev      <= 1'b0;
            enc_count_o <= '0;
        end else begin
            a_sync <= {a_sync[0], enc_a_i};
            b_sync <= {b_sync[0], enc_b_i};
            a_prev <= a_sync[1];
            b_prev <= b_sync[1];
            // Double transitions leave the count alone
            if (step) begin
                if (count_up)
                    enc_count_o <= enc_count_o + 1'b1;
                else
                    enc_count_o <= enc_count_o - 1'b1;
            end
        end
    end

endmodule

// ==== src/spi_byte_slave.sv ====
// SPI mode 0 slave sampled in sysclk; edges act 3 cycles late, so half period must be >= 8 cycles
module spi_byte_slave (
    input  logic                                   sysclk,
    input  logic                                   watchdog_timer_reset_flag,
    input  logic                                   spi_sck_i,
    input  logic                                   spi_mosi_i,
    input  logic                                   spi_ncs_i,
    input  logic [robocup_pkg::SPI_BYTE_WIDTH-1:0] tx_byte_i,
    output logic                                   spi_miso_o,
    output logic                                   spi_miso_oe_o,
    output logic                                   xfer_start_o,
    output logic                                   xfer_end_o,
    output logic                                   byte_done_o,
    output logic [robocup_pkg::SPI_BYTE_WIDTH-1:0] rx_byte_o
);

    localparam int BW    = robocup_pkg::SPI_BYTE_WIDTH;
    localparam int CNT_W = $clog2(BW);

    logic [1:0]       sck_sync;
    logic [1:0]       mosi_sync;
    logic [1:0]       ncs_sync;
    logic             sck_prev;
    logic             ncs_prev;
    logic             start_q;
    logic [CNT_W-1:0] bit_cnt;
    logic [BW-1:0]    rx_shift;
    logic [BW-1:0]    tx_shift;
    logic             selected;
    logic             sck_rise;
    logic             sck_fall;
    logic             last_bit;

    // SCK edges only count while selected
    assign selected = ~ncs_sync[1];
    assign sck_rise = selected & sck_sync[1] & ~sck_prev;
    assign sck_fall = selected & ~sck_sync[1] & sck_prev;
    assign last_bit = (bit_cnt == CNT_W'(BW - 1));

    assign xfer_start_o  = ~ncs_sync[1] & ncs_prev;
    assign xfer_end_o    = ncs_sync[1] & ~ncs_prev;
    assign spi_miso_oe_o = selected;
    assign spi_miso_o    = tx_shift[BW-1];

    // Pin synchronizers, chip select idles high
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            sck_sync  <= '0;
            mosi_sync <= '0;
            ncs_sync  <= '1;
            sck_prev  <= 1'b0;
            ncs_prev  <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            ncs_sync  <= {ncs_sync[0], spi_ncs_i};
            sck_prev  <= sck_sync[1];
            ncs_prev  <= ncs_sync[1];
        end
    end

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            start_q     <= 1'b0;
            bit_cnt     <= '0;
            tx_shift    <= '0;
            byte_done_o <= 1'b0;
        end else begin
            start_q     <= xfer_start_o;
            byte_done_o <= sck_rise & last_bit;
            if (xfer_start_o)
                bit_cnt <= '0;
            else if (sck_rise)
                bit_cnt <= bit_cnt + 1'b1;
            // Byte 0 loads once the status byte is captured
            if (start_q)
                tx_shift <= tx_byte_i;
            // Falling edge at a byte boundary loads the next byte, otherwise shift
            else if (sck_fall)
                tx_shift <= (bit_cnt == '0) ? tx_byte_i : {tx_shift[BW-2:0], 1'b0};
        end
    end

    // MOSI shifts in on rising edges
    always_ff @(posedge sysclk) begin
        if (sck_rise)
            rx_shift <= {rx_shift[BW-2:0], mosi_sync[1]};
        if (sck_rise && last_bit)
            rx_byte_o <= {rx_shift[BW-2:0], mosi_sync[1]};
    end

endmodule

// ==== src/spi_command_handler.sv ====
// Command layer; WDT_WIDTH must be 16 or less, transfers past RESP_BUF_LEN bytes read FILL_BYTE
module spi_command_handler #(
    parameter int NUM_MOTORS = 5,
    parameter int WDT_WIDTH  = 16
) (
    input  logic                                   sysclk,
    input  logic                                   watchdog_timer_reset_flag,
    input  logic                                   sys_rdy_i,
    input  logic                                   wdt_trigger_i,
    input  logic [WDT_WIDTH-1:0]                   wdt_count_i,
    input  logic                                   xfer_start_i,
    input  logic                                   xfer_end_i,
    input  logic                                   byte_done_i,
    input  logic [robocup_pkg::SPI_BYTE_WIDTH-1:0] rx_byte_i,
    input  logic [NUM_MOTORS-2:0][robocup_pkg::ENC_COUNT_WIDTH-1:0] enc_count_i,
    output logic [robocup_pkg::SPI_BYTE_WIDTH-1:0] tx_byte_o,
    output logic                                   wdt_kick_o,
    output logic                                   motors_en_o
);

    localparam int NUM_ENC = NUM_MOTORS - 1;
    localparam int BW      = robocup_pkg::SPI_BYTE_WIDTH;
    localparam int BUF_LEN = robocup_pkg::RESP_BUF_LEN;
    localparam int CNT_W   = $clog2(BUF_LEN + 1);
    localparam int WORD_W  = 2 * BW;

    robocup_pkg::cmd_byte_u req_buf [BUF_LEN];
    logic [BW-1:0]          res_buf [BUF_LEN];
    logic [robocup_pkg::DUTY_WIDTH-1:0] duty [NUM_MOTORS];

    logic [CNT_W-1:0]  byte_cnt;
    logic              cmd_rdy_q;
    logic              act_q;
    logic              en_q;
    logic              en_prev;
    logic              rdy_prev;
    logic              upd_kick_q;
    logic [WORD_W-1:0] wdt_word;
    logic              cmd_is_read;

    assign wdt_word    = WORD_W'(wdt_count_i);
    assign cmd_is_read = (req_buf[0].cmd.rw == robocup_pkg::CMD_READ);

    // Byte index past the buffer answers with the fill pattern
    assign tx_byte_o = (byte_cnt < CNT_W'(BUF_LEN)) ? res_buf[byte_cnt] : robocup_pkg::FILL_BYTE;

    // A watchdog trip holds the motors off without losing the enable request
    assign motors_en_o = en_q & ~wdt_trigger_i;
    // Kick on a good motor update or on any enable rise
    assign wdt_kick_o  = upd_kick_q | (en_q & ~en_prev);

    // Byte counter and pipeline strobes
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            byte_cnt  <= '0;
            cmd_rdy_q <= 1'b0;
            act_q     <= 1'b0;
        end else begin
            cmd_rdy_q <= byte_done_i && (byte_cnt == '0);
            act_q     <= xfer_end_i;
            if (xfer_start_i)
                byte_cnt <= '0;
            else if (byte_done_i && byte_cnt != '1)
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // Request store, status capture and read response fill
    always_ff @(posedge sysclk) begin
        if (byte_done_i && byte_cnt < CNT_W'(BUF_LEN))
            req_buf[byte_cnt].raw <= rx_byte_i;
        if (xfer_start_i)
            res_buf[0] <= {sys_rdy_i, wdt_trigger_i, motors_en_o, {(BW - 3){1'b0}}};
        if (cmd_rdy_q && cmd_is_read) begin
            case (req_buf[0].cmd.code)
                robocup_pkg::CMD_UPDATE_MTRS, robocup_pkg::CMD_ENCODER_COUNT: begin
                    for (int j = 0; j < NUM_ENC; j++) begin
                        res_buf[2*j+1] <= enc_count_i[j][WORD_W-1:BW];
                        res_buf[2*j+2] <= enc_count_i[j][BW-1:0];
                    end
                    res_buf[2*NUM_ENC+1] <= wdt_word[WORD_W-1:BW];
                    res_buf[2*NUM_ENC+2] <= wdt_word[BW-1:0];
                end
                robocup_pkg::CMD_DUTY_CYCLE: begin
                    for (int j = 0; j < NUM_MOTORS; j++) begin
                        res_buf[2*j+1] <= BW'(duty[j] >> BW);
                        res_buf[2*j+2] <= duty[j][BW-1:0];
                    end
                end
                default: begin
                    for (int j = 1; j < BUF_LEN; j++)
                        res_buf[j] <= robocup_pkg::FILL_BYTE;
                end
            endcase
        end
    end

    // End-of-transfer actions, duty cycles and motor enable
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            en_q       <= 1'b0;
            en_prev    <= 1'b0;
            rdy_prev   <= 1'b0;
            upd_kick_q <= 1'b0;
            for (int j = 0; j < NUM_MOTORS; j++)
                duty[j] <= '0;
        end else begin
            en_prev    <= en_q;
            rdy_prev   <= sys_rdy_i;
            upd_kick_q <= 1'b0;
            // Enable once, the cycle after the system comes ready
            if (sys_rdy_i && !rdy_prev)
                en_q <= 1'b1;
            if (act_q) begin
                // Motor update needs the command plus two bytes per motor
                if (cmd_is_read && req_buf[0].cmd.code == robocup_pkg::CMD_UPDATE_MTRS
                        && byte_cnt == CNT_W'(1 + 2 * NUM_MOTORS)) begin
                    for (int j = 0; j < NUM_MOTORS; j++)
                        duty[j] <= robocup_pkg::DUTY_WIDTH'({req_buf[2*j+2].raw,
                                                             req_buf[2*j+1].raw});
                    en_q       <= 1'b1;
                    upd_kick_q <= 1'b1;
                end
                // Toggle carries exactly one extra byte
                if (req_buf[0].cmd.code == robocup_pkg::CMD_TOGGLE_MOTOR_EN
                        && byte_cnt == CNT_W'(2))
                    en_q <= cmd_is_read;
            end
        end
    end

endmodule

// ==== src/system_supervisor.sv ====
// Startup delay and watchdog; timeout is 2^(WDT_PRESCALE_WIDTH+WDT_WIDTH) cycles without a kick
module system_supervisor #(
    parameter int STARTUP_DELAY_WIDTH = 5,
    parameter int WDT_PRESCALE_WIDTH  = 5,
    parameter int WDT_WIDTH           = 16
) (
    input  logic                 sysclk,
    input  logic                 watchdog_timer_reset_flag,
    input  logic                 wdt_kick_i,
    output logic                 sys_rdy_o,
    output logic                 wdt_trigger_o,
    output logic [WDT_WIDTH-1:0] wdt_count_o
);

    logic [STARTUP_DELAY_WIDTH-1:0] start_cnt;
    logic [WDT_PRESCALE_WIDTH-1:0]  prescale_cnt;
    logic                           wdt_tick;

    // One watchdog step per full prescaler turn
    assign wdt_tick = sys_rdy_o && (prescale_cnt == '1);

    // Ready goes high the cycle after the counter saturates
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            start_cnt <= '0;
            sys_rdy_o <= 1'b0;
        end else if (!sys_rdy_o) begin
            if (start_cnt == '1)
                sys_rdy_o <= 1'b1;
            else
                start_cnt <= start_cnt + 1'b1;
        end
    end

    // Prescaler only runs once ready
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag || !sys_rdy_o)
            prescale_cnt <= '0;
        else
            prescale_cnt <= prescale_cnt + 1'b1;
    end

    // Kick wins over a tick in the same cycle
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            wdt_count_o   <= '0;
            wdt_trigger_o <= 1'b0;
        end else if (wdt_kick_i) begin
            wdt_count_o   <= '0;
            wdt_trigger_o <= 1'b0;
        end else if (wdt_tick) begin
            // Wrap from the maximum trips the watchdog
            if (wdt_count_o == '1)
                wdt_trigger_o <= 1'b1;
            wdt_count_o <= wdt_count_o + 1'b1;
        end
    end

endmodule

// ==== src/robocup_top.sv ====
// Host SPI core of the motor board; SCK half period must be at least 8 sysclk cycles
module robocup_top #(
    parameter int NUM_MOTORS          = 5,
    parameter int STARTUP_DELAY_WIDTH = 5,
    parameter int WDT_PRESCALE_WIDTH  = 5,
    parameter int WDT_WIDTH           = 16
) (
    input  logic                  sysclk,
    input  logic                  watchdog_timer_reset_flag,
    input  logic [NUM_MOTORS-2:0] enc_a_i,
    input  logic [NUM_MOTORS-2:0] enc_b_i,
    input  logic                  spi_sck_i,
    input  logic                  spi_mosi_i,
    input  logic                  spi_ncs_i,
    output logic                  spi_miso_o,
    output logic                  spi_miso_oe_o,
    output logic                  motors_en_o
);

    // One encoder per motor except the last
    localparam int NUM_ENC = NUM_MOTORS - 1;

    logic                 sys_rdy;
    logic                 wdt_trigger;
    logic [WDT_WIDTH-1:0] wdt_count;
    logic                 wdt_kick;

    logic                                    xfer_start;
    logic                                    xfer_end;
    logic                                    byte_done;
    logic [robocup_pkg::SPI_BYTE_WIDTH-1:0]  rx_byte;
    logic [robocup_pkg::SPI_BYTE_WIDTH-1:0]  tx_byte;

    logic [NUM_ENC-1:0][robocup_pkg::ENC_COUNT_WIDTH-1:0] enc_count;

    // Startup delay and watchdog
    system_supervisor #(
        .STARTUP_DELAY_WIDTH (STARTUP_DELAY_WIDTH),
        .WDT_PRESCALE_WIDTH  (WDT_PRESCALE_WIDTH),
        .WDT_WIDTH           (WDT_WIDTH)
    ) system_supervisor_i (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .wdt_kick_i                (wdt_kick),
        .sys_rdy_o                 (sys_rdy),
        .wdt_trigger_o             (wdt_trigger),
        .wdt_count_o               (wdt_count)
    );

    // Pin-level SPI slave, bytes in and out
    spi_byte_slave spi_byte_slave_i (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .spi_sck_i                 (spi_sck_i),
        .spi_mosi_i                (spi_mosi_i),
        .spi_ncs_i                 (spi_ncs_i),
        .tx_byte_i                 (tx_byte),
        .spi_miso_o                (spi_miso_o),
        .spi_miso_oe_o             (spi_miso_oe_o),
        .xfer_start_o              (xfer_start),
        .xfer_end_o                (xfer_end),
        .byte_done_o               (byte_done),
        .rx_byte_o                 (rx_byte)
    );

    // Command decode, buffers, duty cycles and enable
    spi_command_handler #(
        .NUM_MOTORS (NUM_MOTORS),
        .WDT_WIDTH  (WDT_WIDTH)
    ) spi_command_handler_i (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .sys_rdy_i                 (sys_rdy),
        .wdt_trigger_i             (wdt_trigger),
        .wdt_count_i               (wdt_count),
        .xfer_start_i              (xfer_start),
        .xfer_end_i                (xfer_end),
        .byte_done_i               (byte_done),
        .rx_byte_i                 (rx_byte),
        .enc_count_i               (enc_count),
        .tx_byte_o                 (tx_byte),
        .wdt_kick_o                (wdt_kick),
        .motors_en_o               (motors_en_o)
    );

    // One counter per encoder channel
    for (genvar i = 0; i < NUM_ENC; i++) begin : gen_enc
        quad_encoder_counter quad_encoder_counter_i (
            .sysclk                    (sysclk),
            .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
            .enc_a_i                   (enc_a_i[i]),
            .enc_b_i                   (enc_b_i[i]),
            .enc_count_o               (enc_count[i])
        );
    end

endmodule

// ==== verification/robocup_props.sv ====
// Bound into robocup_top; all checks are disabled while watchdog_timer_reset_flag is high
module robocup_props #(
    parameter int WDT_WIDTH = 16
) (
    input logic                 sysclk,
    input logic                 watchdog_timer_reset_flag,
    input logic                 spi_ncs_i,
    input logic                 spi_miso_oe_o,
    input logic                 motors_en_o,
    input logic                 byte_done,
    input logic                 wdt_trigger,
    input logic                 wdt_kick,
    input logic [WDT_WIDTH-1:0] wdt_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions, read by the testbench at the end
    int fail_cnt = 0;

    // One byte takes far more than two cycles
    a_byte_done_pulse: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        byte_done |=> !byte_done)
        else begin
            $error("byte_done high two cycles in a row");
            fail_cnt++;
        end

    // Two sync flops plus edge detect before the output enable drops
    a_oe_release: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        $rose(spi_ncs_i) |-> ##3 !spi_miso_oe_o)
        else begin
            $error("spi_miso_oe_o still high after chip select rose");
            fail_cnt++;
        end

    a_trigger_holds_off: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        wdt_trigger |-> !motors_en_o)
        else begin
            $error("motors enabled while the watchdog trigger is set");
            fail_cnt++;
        end

    a_kick_clears: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        wdt_kick |=> (wdt_count == '0))
        else begin
            $error("watchdog count not cleared after a kick");
            fail_cnt++;
        end

endmodule

bind robocup_top robocup_props #(.WDT_WIDTH(WDT_WIDTH)) robocup_props_i (
    .sysclk                    (sysclk),
    .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
    .spi_ncs_i                 (spi_ncs_i),
    .spi_miso_oe_o             (spi_miso_oe_o),
    .motors_en_o               (motors_en_o),
    .byte_done                 (byte_done),
    .wdt_trigger               (wdt_trigger),
    .wdt_kick                  (wdt_kick),
    .wdt_count                 (wdt_count)
);

// ==== verification/robocup_tb.sv ====
// Plays the stim file against the DUT; SCK half period is 10 sysclk cycles, ENC and WAIT are decimal
module robocup_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_MOTORS = 5;
    localparam int NUM_ENC    = NUM_MOTORS - 1;
    localparam int BW         = robocup_pkg::SPI_BYTE_WIDTH;
    localparam int BUF_LEN    = robocup_pkg::RESP_BUF_LEN;
    localparam int HALF       = 10;
    localparam int STEP_HOLD  = 4;

    // Record kinds from the stim file
    localparam int K_ENC  = 0;
    localparam int K_XFER = 1;
    localparam int K_WAIT = 2;
    localparam int K_EN   = 3;

    logic                sysclk;
    logic                watchdog_timer_reset_flag;
    logic [NUM_ENC-1:0]  enc_a;
    logic [NUM_ENC-1:0]  enc_b;
    logic                spi_sck;
    logic                spi_mosi;
    logic                spi_ncs;
    logic                spi_miso;
    logic                spi_miso_oe;
    logic                motors_en;

    // Parsed records, all numeric fields in one flat queue
    int kind_q[$];
    int val_q[$];
    int cycle_limit;
    int cycle_cnt;
    int error_cnt;
    int check_cnt;
    int test_cnt;

    // Current transfer, one entry per byte
    logic [BW-1:0] mosi_bytes [BUF_LEN];
    logic [BW-1:0] exp_bytes  [BUF_LEN];
    logic [BW-1:0] mask_bytes [BUF_LEN];

    // Gray phase of each encoder, 0..3
    int enc_phase [NUM_ENC];

    robocup_top #(
        .NUM_MOTORS          (NUM_MOTORS),
        .STARTUP_DELAY_WIDTH (5),
        .WDT_PRESCALE_WIDTH  (2),
        .WDT_WIDTH           (8)
    ) robocup_top_i (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .enc_a_i                   (enc_a),
        .enc_b_i                   (enc_b),
        .spi_sck_i                 (spi_sck),
        .spi_mosi_i                (spi_mosi),
        .spi_ncs_i                 (spi_ncs),
        .spi_miso_o                (spi_miso),
        .spi_miso_oe_o             (spi_miso_oe),
        .motors_en_o               (motors_en)
    );

    initial sysclk = 1'b0;
    always #20 sysclk = ~sysclk;

    // Run limit, armed once the file is parsed
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Inputs change 2 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #2;
    endtask

    task automatic check_byte(input string name, input logic [BW-1:0] exp,
                              input logic [BW-1:0] act, input logic [BW-1:0] mask);
        check_cnt++;
        if ((act & mask) !== (exp & mask)) begin
            error_cnt++;
            $display("Fail %s: expected 0x%02h, got 0x%02h, mask 0x%02h", name, exp, act, mask);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endtask

    // A leads B going up: 00 10 11 01
    function automatic logic [1:0] gray_ab(input int phase);
        case (phase)
            0: gray_ab = 2'b00;
            1: gray_ab = 2'b10;
            2: gray_ab = 2'b11;
            default: gray_ab = 2'b01;
        endcase
    endfunction

    task automatic step_encoder(input int e, input int steps);
        logic [1:0] ab;
        int k;
        for (k = 0; k < (steps < 0 ? -steps : steps); k++) begin
            enc_phase[e] = (steps < 0) ? (enc_phase[e] + 3) % 4 : (enc_phase[e] + 1) % 4;
            ab = gray_ab(enc_phase[e]);
            enc_a[e] = ab[1];
            enc_b[e] = ab[0];
            wait_cycles(STEP_HOLD);
        end
    endtask

    // Mode 0, MSB first; MISO read just before each rising SCK
    task automatic play_xfer(input int n);
        logic [BW-1:0] got;
        int b;
        int i;
        spi_ncs = 1'b0;
        wait_cycles(HALF);
        // Output enable follows the synchronized chip select
        check_level("spi_miso_oe_o", 1'b1, spi_miso_oe);
        for (b = 0; b < n; b++) begin
            got = '0;
            for (i = BW - 1; i >= 0; i--) begin
                spi_mosi = mosi_bytes[b][i];
                wait_cycles(HALF);
                got[i] = spi_miso;
                spi_sck = 1'b1;
                wait_cycles(HALF);
                spi_sck = 1'b0;
            end
            check_byte($sformatf("spi_miso_o byte %0d", b), exp_bytes[b], got, mask_bytes[b]);
        end
        wait_cycles(HALF);
        spi_ncs = 1'b1;
        wait_cycles(HALF);
        check_level("spi_miso_oe_o", 1'b0, spi_miso_oe);
    endtask

    task automatic parse_stim();
        int fd;
        int r;
        int v;
        int n;
        int k;
        string kw;
        string rest;
        fd = $fopen("verification/robocup_stim.txt", "r");
        cycle_limit = 0;
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            error_cnt++;
        end else begin
            while (!$feof(fd)) begin
                r = $fscanf(fd, "%s", kw);
                if (r != 1)
                    break;
                if (kw == "#") begin
                    r = $fgets(rest, fd);
                end else if (kw == "ENC") begin
                    kind_q.push_back(K_ENC);
                    for (k = 0; k < NUM_ENC; k++) begin
                        r = $fscanf(fd, "%d", v);
                        val_q.push_back(v);
                        cycle_limit += STEP_HOLD * (v < 0 ? -v : v);
                    end
                end else if (kw == "XFER") begin
                    kind_q.push_back(K_XFER);
                    r = $fscanf(fd, "%h", n);
                    val_q.push_back(n);
                    for (k = 0; k < 3 * n; k++) begin
                        r = $fscanf(fd, "%h", v);
                        val_q.push_back(v);
                    end
                    cycle_limit += n * (2 * HALF * BW + HALF) + 3 * HALF;
                end else if (kw == "WAIT") begin
                    kind_q.push_back(K_WAIT);
                    r = $fscanf(fd, "%d", v);
                    val_q.push_back(v);
                    cycle_limit += v;
                end else if (kw == "EN") begin
                    kind_q.push_back(K_EN);
                    r = $fscanf(fd, "%h", v);
                    val_q.push_back(v);
                    cycle_limit += 1;
                end else begin
                    $display("Unknown record keyword %s in the stimulus file", kw);
                    error_cnt++;
                end
            end
            $fclose(fd);
        end
        // Reset and startup on top, then double it
        cycle_limit = 2 * (cycle_limit + 100);
    endtask

    initial begin
        int kind;
        int n;
        int k;
        int errs_before;
        watchdog_timer_reset_flag = 1'b1;
        enc_a       = '0;
        enc_b       = '0;
        spi_sck     = 1'b0;
        spi_mosi    = 1'b0;
        spi_ncs     = 1'b1;
        cycle_cnt   = 0;
        cycle_limit = 0;
        error_cnt   = 0;
        check_cnt   = 0;
        test_cnt    = 0;
        for (k = 0; k < NUM_ENC; k++)
            enc_phase[k] = 0;
        parse_stim();
        wait_cycles(5);
        watchdog_timer_reset_flag = 1'b0;

        while (kind_q.size() > 0) begin
            kind = kind_q.pop_front();
            errs_before = error_cnt;
            case (kind)
                K_ENC: begin
                    for (k = 0; k < NUM_ENC; k++)
                        step_encoder(k, val_q.pop_front());
                end
                K_XFER: begin
                    n = val_q.pop_front();
                    for (k = 0; k < n; k++)
                        mosi_bytes[k] = BW'(val_q.pop_front());
                    for (k = 0; k < n; k++)
                        exp_bytes[k] = BW'(val_q.pop_front());
                    for (k = 0; k < n; k++)
                        mask_bytes[k] = BW'(val_q.pop_front());
                    play_xfer(n);
                    test_cnt++;
                    $display("test %0d: transfer of %0d bytes, command 0x%02h, %s", test_cnt,
                             n, mosi_bytes[0], (error_cnt == errs_before) ? "ok" : "errors");
                end
                K_WAIT: begin
                    wait_cycles(val_q.pop_front());
                end
                default: begin
                    check_level("motors_en_o", 1'(val_q.pop_front()), motors_en);
                    test_cnt++;
                    $display("test %0d: motors_en_o level, %s", test_cnt,
                             (error_cnt == errs_before) ? "ok" : "errors");
                end
            endcase
        end

        // Bound checker failures count as errors of the run
        if (robocup_top_i.robocup_props_i.fail_cnt > 0) begin
            $display("%0d assertion failures in the bound checker",
                     robocup_top_i.robocup_props_i.fail_cnt);
            error_cnt += robocup_top_i.robocup_props_i.fail_cnt;
        end

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/robocup_stim.txt ====
# XFER n, then n MOSI bytes, n expected MISO bytes, n compare masks (hex); EN level (hex)
# ENC signed steps per encoder and WAIT cycles are decimal
WAIT 60
EN 1
XFER b 91 00 00 00 00 00 00 00 00 00 00 a0 00 00 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff ff 00 00
ENC 3 -2 5 0
XFER b 91 00 00 00 00 00 00 00 00 00 00 80 00 03 ff fe 00 05 00 00 00 00 9f ff ff ff ff ff ff ff ff 00 00
XFER b 80 23 01 ff 03 00 00 a5 02 55 01 80 00 03 ff fe 00 05 00 00 00 00 9f ff ff ff ff ff ff ff ff 00 00
EN 1
XFER b 93 00 00 00 00 00 00 00 00 00 00 a0 01 23 03 ff 00 00 02 a5 01 55 ff ff ff ff ff ff ff ff ff ff ff
XFER 9 80 00 00 00 00 00 00 00 00 80 00 00 00 00 00 00 00 00 9f 00 00 00 00 00 00 00 00
XFER b 93 00 00 00 00 00 00 00 00 00 00 80 01 23 03 ff 00 00 02 a5 01 55 9f ff ff ff ff ff ff ff ff ff ff
XFER c ff 00 00 00 00 00 00 00 00 00 00 00 80 aa aa aa aa aa aa aa aa aa aa aa 9f ff ff ff ff ff ff ff ff ff ff ff
XFER 2 30 00 80 00 80 00
EN 0
XFER 2 b0 00 80 00 80 00
EN 1
XFER 3 30 00 00 a0 00 00 ff 00 00
EN 1
WAIT 1100
EN 0
XFER b 91 00 00 00 00 00 00 00 00 00 00 c0 00 03 ff fe 00 05 00 00 00 00 ff ff ff ff ff ff ff ff ff 00 00
XFER b 80 23 01 ff 03 00 00 a5 02 55 01 c0 00 03 ff fe 00 05 00 00 00 00 ff ff ff ff ff ff ff ff ff 00 00
EN 1
XFER 2 91 00 a0 00 ff ff

// ==== compile.f ====
src/robocup_pkg.sv
src/quad_encoder_counter.sv
src/spi_byte_slave.sv
src/spi_command_handler.sv
src/system_supervisor.sv
src/robocup_top.sv
verification/robocup_props.sv
verification/robocup_tb.sv

// ==== Makefile ====
# Verilator build for the robocup testbench; override variables on the command line
VERILATOR ?= verilator
TOP       ?= robocup_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
